/* files.f */
dataPathPkg.sv
regPortIf.sv
regFile.sv
aluCore.sv
execStage.sv
microDataPath.sv
tbClockGen.sv
tbMicroDataPath.sv

/* run.sh */
#!/bin/sh
# compile and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tbMicroDataPath \
	-o simMicroDataPath
# the simulator exits non-zero on a fatal error, the log decides the outcome
./obj_dir/simMicroDataPath > sim.log 2>&1 || true
cat sim.log
if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	exit 1
fi
if ! grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
	exit 1
fi
exit 0

/* tbMicroDataPath.sv */
//----------------------------
// datapath testbench
// random and directed micro-operations checked against a register
// model, with back-pressure on the result port
//----------------------------
`timescale 1ns/1ns

module tbMicroDataPath;
	import dataPathPkg::*;

	typedef struct packed {
		regSel_t selA;
		regSel_t selB;
		regSel_t writeSel;
		aluFunc_t func;
		word_t imm;
	} microOp_t;

	typedef struct packed {
		word_t data;
		aluFlags_t flags;
	} result_t;

	logic clock50;
	logic arstN;
	logic opValid;
	regSel_t opSelA;
	regSel_t opSelB;
	regSel_t opWriteSel;
	aluFunc_t opAluFunc;
	word_t opImm;
	logic resReady;
	logic opReady;
	logic resValid;
	word_t resData;
	logic resOverflow;
	logic resCarry;
	logic resNegative;
	logic resZero;
	word_t displayData;

	// register model, slot 0 is never written
	word_t modelReg [0:regCount-1];
	// results still owed by the DUT, oldest first
	result_t pendingQ [$];
	word_t lastData;
	aluFlags_t lastFlags;
	logic stallMode;
	int lastWait;
	string testName;

	tbClockGen clockGen_i (
		.clock50(clock50),
		.arstN(arstN)
	);

	microDataPath dut_i (
		.clock50(clock50),
		.arstN(arstN),
		.opValid(opValid),
		.opSelA(opSelA),
		.opSelB(opSelB),
		.opWriteSel(opWriteSel),
		.opAluFunc(opAluFunc),
		.opImm(opImm),
		.resReady(resReady),
		.opReady(opReady),
		.resValid(resValid),
		.resData(resData),
		.resOverflow(resOverflow),
		.resCarry(resCarry),
		.resNegative(resNegative),
		.resZero(resZero),
		.displayData(displayData)
	);

	//----------------------------
	// error handling and compares
	//----------------------------
	task automatic stopRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkWord(input string what, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			stopRun($sformatf("ERR %s %s expected %h actual %h", testName, what, expected, actual));
		end
	endtask

	task automatic checkFlags(input string what, input aluFlags_t expected,
			input aluFlags_t actual);
		if (actual !== expected) begin
			stopRun($sformatf("ERR %s %s expected %b actual %b", testName, what, expected, actual));
		end
	endtask

	task automatic checkBit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			stopRun($sformatf("ERR %s %s expected %b actual %b", testName, what, expected, actual));
		end
	endtask

	function automatic aluFlags_t flagSet(input logic ovf, input logic cy, input logic neg,
			input logic zer);
		aluFlags_t f;
		f.overflow = ovf;
		f.carry = cy;
		f.negative = neg;
		f.zero = zer;
		return f;
	endfunction

	//----------------------------
	// reference model
	//----------------------------
	// R0 and codes past IR read as zero
	function automatic word_t modelRead(input regSel_t sel);
		if (sel == '0 || sel > idxIr) begin
			return '0;
		end
		return modelReg[sel];
	endfunction

	function automatic result_t modelAlu(input word_t a, input word_t b, input aluFunc_t func);
		result_t r;
		logic [dataWidth:0] sum;
		r.flags = '0;
		r.data = '0;
		case (func)
			aluAdd: begin
				sum = {1'b0, a} + {1'b0, b};
				r.data = sum[dataWidth-1:0];
				r.flags.carry = sum[dataWidth];
				// two operands of one sign giving the other sign
				r.flags.overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
					(r.data[dataWidth-1] != a[dataWidth-1]);
			end
			aluSub: begin
				r.data = a - b;
				// carry reports a borrow
				r.flags.carry = (a < b);
				r.flags.overflow = (a[dataWidth-1] != b[dataWidth-1]) &&
					(r.data[dataWidth-1] != a[dataWidth-1]);
			end
			aluAnd: r.data = a & b;
			aluOr: r.data = a | b;
			aluXor: r.data = a ^ b;
			aluAndn: r.data = a & ~b;
			aluOrn: r.data = a | ~b;
			aluXnor: r.data = ~(a ^ b);
			aluPassA: r.data = a;
			aluPassB: r.data = b;
			default: r.data = '0;
		endcase
		r.flags.negative = r.data[dataWidth-1];
		r.flags.zero = (r.data == '0);
		return r;
	endfunction

	//----------------------------
	// one clock of stimulus and checking
	//----------------------------
	// drives on the falling edge, samples 1 ns later when everything has settled
	task automatic cycleStep(input logic offer, input microOp_t op, output logic taken);
		aluFlags_t actFlags;
		result_t predicted;
		logic slotFull;
		@(negedge clock50);
		checkWord("display", modelReg[idxDisplay], displayData);
		opValid = offer;
		opSelA = op.selA;
		opSelB = op.selB;
		opWriteSel = op.writeSel;
		opAluFunc = op.func;
		opImm = op.imm;
		resReady = stallMode ? 1'($urandom % 2) : 1'b1;
		#1;
		// the result slot is full exactly while an accepted operation is still owed
		slotFull = (pendingQ.size() != 0);
		checkBit("resValid", slotFull, resValid);
		if (slotFull) begin
			actFlags = flagSet(resOverflow, resCarry, resNegative, resZero);
			// a stalled result is checked on every cycle it is held
			checkWord("result data", pendingQ[0].data, resData);
			checkFlags("result flags", pendingQ[0].flags, actFlags);
			if (resReady) begin
				lastData = resData;
				lastFlags = actFlags;
				void'(pendingQ.pop_front());
			end
		end
		checkBit("opReady", !slotFull || resReady, opReady);
		taken = offer && opReady;
		// the bank is written on the same edge that accepts the operation
		if (taken) begin
			predicted = modelAlu(modelRead(op.selA),
				(op.selB == selImm) ? op.imm : modelRead(op.selB), op.func);
			pendingQ.push_back(predicted);
			if (op.writeSel != '0 && op.writeSel <= idxIr) begin
				modelReg[op.writeSel] = predicted.data;
			end
		end
	endtask

	task automatic sendOp(input regSel_t selA, input regSel_t selB, input aluFunc_t func,
			input regSel_t writeSel, input word_t imm);
		microOp_t op;
		logic taken;
		op.selA = selA;
		op.selB = selB;
		op.func = func;
		op.writeSel = writeSel;
		op.imm = imm;
		lastWait = 0;
		cycleStep(1'b1, op, taken);
		while (!taken) begin
			lastWait++;
			if (lastWait >= 200) begin
				stopRun("timeout: opReady stayed low for 200 cycles");
			end
			cycleStep(1'b1, op, taken);
		end
	endtask

	task automatic randomOp();
		regSel_t selB;
		// about one operand in four comes from the immediate
		selB = ($urandom % 4 == 0) ? selImm : regSel_t'($urandom % regCount);
		sendOp(regSel_t'($urandom % regCount), selB, aluFunc_t'(4'($urandom % 10)),
			regSel_t'($urandom % 64), $urandom());
	endtask

	task automatic drainResults();
		microOp_t idle;
		logic taken;
		int waited;
		idle = '0;
		waited = 0;
		while (pendingQ.size() != 0) begin
			if (waited >= 200) begin
				stopRun("timeout: results still missing after 200 cycles");
			end
			cycleStep(1'b0, idle, taken);
			waited++;
		end
	endtask

	//----------------------------
	// test sequence
	//----------------------------
	initial begin
		int waited;
		void'($urandom(32'h71a5_c872));
		opValid = 1'b0;
		opSelA = '0;
		opSelB = '0;
		opWriteSel = '0;
		opAluFunc = aluAdd;
		opImm = '0;
		resReady = 1'b0;
		stallMode = 1'b0;
		lastWait = 0;
		for (int i = 0; i < regCount; i++) begin
			modelReg[i] = '0;
		end

		testName = "resetState";
		waited = 0;
		while (arstN !== 1'b1) begin
			if (waited >= 200) begin
				stopRun("timeout: reset was never released");
			end
			@(negedge clock50);
			#1;
			waited++;
		end
		checkBit("resValid", 1'b0, resValid);
		checkBit("opReady", 1'b1, opReady);
		checkWord("display", '0, displayData);
		// every register ORed with itself has to come back as zero
		for (int s = 0; s < regCount; s++) begin
			sendOp(regSel_t'(s), regSel_t'(s), aluOr, '0, '0);
		end
		drainResults();

		testName = "loadDecode";
		for (int s = 1; s < regCount; s++) begin
			sendOp('0, selImm, aluPassB, regSel_t'(s), $urandom());
		end
		// these targets must leave the bank alone
		sendOp('0, selImm, aluPassB, '0, 32'hdead_0000);
		sendOp('0, selImm, aluPassB, regSel_t'(regCount), 32'hdead_0026);
		sendOp('0, selImm, aluPassB, selImm, 32'hdead_003f);
		for (int i = 0; i < 60; i++) begin
			sendOp(regSel_t'($urandom % regCount), selImm, aluPassB,
				regSel_t'($urandom % 64), $urandom());
		end
		for (int s = 0; s < 64; s++) begin
			sendOp(regSel_t'(s), '0, aluPassA, '0, '0);
		end
		drainResults();

		testName = "aluFlags";
		for (int i = 0; i < 200; i++) begin
			randomOp();
		end
		drainResults();
		sendOp('0, selImm, aluPassB, 6'd2, 32'hffff_ffff);
		sendOp(6'd2, selImm, aluAdd, idxPc, 32'd1);
		drainResults();
		checkWord("all ones plus one", '0, lastData);
		checkFlags("all ones plus one", flagSet(1'b0, 1'b1, 1'b0, 1'b1), lastFlags);
		sendOp('0, selImm, aluPassB, 6'd3, 32'h7fff_ffff);
		sendOp(6'd3, selImm, aluAdd, idxIr, 32'd1);
		drainResults();
		checkWord("signed overflow", 32'h8000_0000, lastData);
		checkFlags("signed overflow", flagSet(1'b1, 1'b0, 1'b1, 1'b0), lastFlags);
		sendOp('0, selImm, aluSub, idxT0, 32'd1);
		drainResults();
		checkWord("zero minus one", 32'hffff_ffff, lastData);
		checkFlags("zero minus one", flagSet(1'b0, 1'b1, 1'b1, 1'b0), lastFlags);

		testName = "backToBack";
		// a chain through T0 to T3 where each step reads the one before it
		sendOp('0, selImm, aluPassB, idxT0, $urandom());
		for (int i = 0; i < 24; i++) begin
			sendOp(idxT0 + regSel_t'(i % 4), selImm, (i % 2 == 0) ? aluAdd : aluSub,
				idxT0 + regSel_t'((i + 1) % 4), $urandom());
			if (lastWait != 0) begin
				stopRun("operation stalled while resReady was held high");
			end
		end
		sendOp(idxT0, '0, aluPassA, '0, '0);
		drainResults();

		testName = "backPressure";
		stallMode = 1'b1;
		for (int i = 0; i < 150; i++) begin
			randomOp();
		end
		drainResults();

		testName = "display";
		for (int i = 0; i < 20; i++) begin
			sendOp(regSel_t'($urandom % regCount), selImm, aluXor, idxDisplay, $urandom());
		end
		drainResults();
		stallMode = 1'b0;

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* tbClockGen.sv */
//----------------------------
// testbench clock and reset
// 10 ns clock50, arstN low over three rising edges
//----------------------------
`timescale 1ns/1ns

module tbClockGen (
	output logic clock50,
	output logic arstN
);
	// board clock, 10 ns period
	initial begin
		clock50 = 1'b0;
		forever begin
			#5 clock50 = ~clock50;
		end
	end

	// reset spans three rising edges and lets go on a falling edge
	initial begin
		arstN = 1'b0;
		repeat (3) begin
			@(posedge clock50);
		end
		@(negedge clock50);
		arstN = 1'b1;
	end

endmodule

/* microDataPath.sv */
//----------------------------
// microcoded datapath top
// register bank and execute stage behind plain handshake ports
//----------------------------
`timescale 1ns/1ns

module microDataPath (
	input logic clock50,
	input logic arstN,
	input logic opValid,
	input dataPathPkg::regSel_t opSelA,
	input dataPathPkg::regSel_t opSelB,
	input dataPathPkg::regSel_t opWriteSel,
	input dataPathPkg::aluFunc_t opAluFunc,
	input dataPathPkg::word_t opImm,
	input logic resReady,
	output logic opReady,
	output logic resValid,
	output dataPathPkg::word_t resData,
	output logic resOverflow,
	output logic resCarry,
	output logic resNegative,
	output logic resZero,
	output dataPathPkg::word_t displayData
);
	import dataPathPkg::*;

	aluFlags_t resFlags;

	// read and write ports between the stage and the bank
	regPortIf regs_i ();

	regFile regFile_i (
		.clock50(clock50),
		.arstN(arstN),
		.regs(regs_i.bank),
		.display(displayData)
	);

	execStage execStage_i (
		.clock50(clock50),
		.arstN(arstN),
		.opValid(opValid),
		.opReady(opReady),
		.opSelA(opSelA),
		.opSelB(opSelB),
		.opWriteSel(opWriteSel),
		.opAluFunc(opAluFunc),
		.opImm(opImm),
		.regs(regs_i.exec),
		.resValid(resValid),
		.resReady(resReady),
		.resData(resData),
		.resFlags(resFlags)
	);

	// flag struct out to the board pins
	assign resOverflow = resFlags.overflow;
	assign resCarry = resFlags.carry;
	assign resNegative = resFlags.negative;
	assign resZero = resFlags.zero;

endmodule

/* execStage.sv */
//----------------------------
// execute stage
// takes one micro-operation per handshake, runs it through the ALU,
// writes bus C back to the bank and holds the result for the consumer
//----------------------------
`timescale 1ns/1ns

module execStage (
	input logic clock50,
	input logic arstN,
	input logic opValid,
	output logic opReady,
	input dataPathPkg::regSel_t opSelA,
	input dataPathPkg::regSel_t opSelB,
	input dataPathPkg::regSel_t opWriteSel,
	input dataPathPkg::aluFunc_t opAluFunc,
	input dataPathPkg::word_t opImm,
	regPortIf.exec regs,
	output logic resValid,
	input logic resReady,
	output dataPathPkg::word_t resData,
	output dataPathPkg::aluFlags_t resFlags
);
	import dataPathPkg::*;

	word_t busB;
	word_t busC;
	aluFlags_t aluFlags;
	logic accept;

	//----------------------------
	// handshake
	//----------------------------
	// a new operation fits when the result slot is empty or draining now
	assign opReady = !resValid || resReady;
	assign accept = opValid && opReady;

	// operand fetch, the selects go straight to the bank
	assign regs.readSelA = opSelA;
	assign regs.readSelB = opSelB;

	// the reserved code brings the immediate onto bus B
	assign busB = (opSelB == selImm) ? opImm : regs.readDataB;

	aluCore alu_i (
		.busA(regs.readDataA),
		.busB(busB),
		.func(opAluFunc),
		.busC(busC),
		.flags(aluFlags)
	);

	//----------------------------
	// write-back
	//----------------------------
	// only on a transfer, and never to R0 or past IR
	assign regs.writeEn = accept && (opWriteSel != '0) && (opWriteSel <= idxIr);
	assign regs.writeSel = opWriteSel;
	assign regs.writeData = busC;

	// result slot is full after a transfer until the consumer takes it
	always_ff @(posedge clock50 or negedge arstN) begin
		if (!arstN) begin
			resValid <= 1'b0;
		end else if (accept) begin
			resValid <= 1'b1;
		end else if (resReady) begin
			resValid <= 1'b0;
		end
	end

	// result data only moves on a transfer, so it holds under a stall
	always_ff @(posedge clock50) begin
		if (accept) begin
			resData <= busC;
			resFlags <= aluFlags;
		end
	end

	// the sequencer must never offer a function code past aluPassB
	funcLegal: assert property (@(posedge clock50) disable iff (!arstN)
		opValid |-> (opAluFunc <= aluPassB));

	// a stalled result is held until the consumer takes it
	resHeld: assert property (@(posedge clock50) disable iff (!arstN)
		resValid && !resReady |=> resValid && $stable(resData) && $stable(resFlags));

endmodule

/* aluCore.sv */
//----------------------------
// ALU
// combinational bus C result plus overflow, carry, negative and zero
//----------------------------
`timescale 1ns/1ns

module aluCore (
	input dataPathPkg::word_t busA,
	input dataPathPkg::word_t busB,
	input dataPathPkg::aluFunc_t func,
	output dataPathPkg::word_t busC,
	output dataPathPkg::aluFlags_t flags
);
	import dataPathPkg::*;

	// subtract runs through the same adder with B inverted and a carry in
	logic isSub;
	word_t addB;
	logic [dataWidth:0] wide;

	// arithmetic status, left at zero for the logic functions
	logic sumCarry;
	logic sumOverflow;

	//----------------------------
	// shared adder
	//----------------------------
	always_comb begin
		isSub = (func == aluSub);
		addB = isSub ? ~busB : busB;
		wide = {1'b0, busA} + {1'b0, addB} + (dataWidth + 1)'(isSub);
	end

	//----------------------------
	// function select
	//----------------------------
	always_comb begin
		busC = '0;
		sumCarry = 1'b0;
		sumOverflow = 1'b0;
		case (func)
			aluAdd, aluSub: begin
				busC = wide[dataWidth-1:0];
				// the adder carries out when there is no borrow, so flip it for subtract
				sumCarry = wide[dataWidth] ^ isSub;
				// same sign going in and a different sign coming out
				sumOverflow = (busA[dataWidth-1] == addB[dataWidth-1]) &&
					(wide[dataWidth-1] != busA[dataWidth-1]);
			end
			aluAnd: busC = busA & busB;
			aluOr: busC = busA | busB;
			aluXor: busC = busA ^ busB;
			aluAndn: busC = busA & ~busB;
			aluOrn: busC = busA | ~busB;
			aluXnor: busC = ~(busA ^ busB);
			aluPassA: busC = busA;
			aluPassB: busC = busB;
			// illegal codes give zero
			default: busC = '0;
		endcase
	end

	// negative and zero look only at the result
	assign flags.overflow = sumOverflow;
	assign flags.carry = sumCarry;
	assign flags.negative = busC[dataWidth-1];
	assign flags.zero = (busC == '0);

endmodule

/* regFile.sv */
//----------------------------
// register bank
// 38 words with R0 tied to zero, a one-hot write decoder,
// two read selectors for bus A and bus B and the R1 display tap
//----------------------------
`timescale 1ns/1ns

module regFile (
	input logic clock50,
	input logic arstN,
	regPortIf.bank regs,
	output dataPathPkg::word_t display
);
	import dataPathPkg::*;

	// storage starts at R1, R0 has no flops behind it
	word_t bank [1:regCount-1];

	// one enable per stored register
	logic [regCount-1:1] writeDec;

	// true for the codes that map onto a stored register
	function automatic logic inBank(input regSel_t sel);
		return (sel != '0) && (sel <= idxIr);
	endfunction

	//----------------------------
	// write decoder
	//----------------------------
	// at most one bit is set, so only one register moves per edge
	always_comb begin
		writeDec = '0;
		if (regs.writeEn && inBank(regs.writeSel)) begin
			writeDec[regs.writeSel] = 1'b1;
		end
	end

	// bus C is common to all registers, the decoder picks the one that loads
	always_ff @(posedge clock50 or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < regCount; i++) begin
				bank[i] <= '0;
			end
		end else begin
			for (int i = 1; i < regCount; i++) begin
				if (writeDec[i]) begin
					bank[i] <= regs.writeData;
				end
			end
		end
	end

	//----------------------------
	// read selectors
	//----------------------------
	// R0 and every code past IR read back as zero
	always_comb begin
		regs.readDataA = '0;
		if (inBank(regs.readSelA)) begin
			regs.readDataA = bank[regs.readSelA];
		end
	end

	always_comb begin
		regs.readDataB = '0;
		if (inBank(regs.readSelB)) begin
			regs.readDataB = bank[regs.readSelB];
		end
	end

	// display follows R1 one cycle after it is written
	assign display = bank[idxDisplay];

	// the execute stage has to drop writes aimed at R0 or past IR
	writeTargetLegal: assert property (@(posedge clock50) disable iff (!arstN)
		regs.writeEn |-> inBank(regs.writeSel));

endmodule

/* regPortIf.sv */
//----------------------------
// register bank port bundle
// two combinational read ports and one clocked write port
//----------------------------
`timescale 1ns/1ns

interface regPortIf;
	import dataPathPkg::*;

	// read side, selects come in and data goes straight back
	regSel_t readSelA;
	regSel_t readSelB;
	word_t readDataA;
	word_t readDataB;

	// write side, bus C lands in the bank on the clock edge
	logic writeEn;
	regSel_t writeSel;
	word_t writeData;

	// the execute stage owns the selects and the write port
	modport exec (
		output readSelA,
		output readSelB,
		output writeEn,
		output writeSel,
		output writeData,
		input readDataA,
		input readDataB
	);

	// the bank answers reads and accepts writes
	modport bank (
		input readSelA,
		input readSelB,
		input writeEn,
		input writeSel,
		input writeData,
		output readDataA,
		output readDataB
	);

endinterface

/* dataPathPkg.sv */
//----------------------------
// datapath package
// widths, register map, ALU function codes and the status flag
// layout shared by the register bank, the execute stage and the testbench
//----------------------------
package dataPathPkg;

	//----------------------------
	// bus and register bank sizes
	//----------------------------
	localparam int dataWidth = 32;
	typedef logic [dataWidth-1:0] word_t;

	// R0, R1 to R31, PC, T0 to T3 and IR
	localparam int regCount = 38;
	localparam int regSelWidth = 6;
	typedef logic [regSelWidth-1:0] regSel_t;

	// named slots above the general registers
	localparam regSel_t idxPc = 6'd32;
	// T1 to T3 follow T0 directly
	localparam regSel_t idxT0 = 6'd33;
	localparam regSel_t idxIr = 6'd37;

	// the board display always shows R1
	localparam regSel_t idxDisplay = 6'd1;

	// on bus B this code takes the immediate, as a write target it writes nothing
	localparam regSel_t selImm = 6'd63;

	//----------------------------
	// ALU functions, codes 10 to 15 are illegal
	//----------------------------
	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluAnd   = 4'd2,
		aluOr    = 4'd3,
		aluXor   = 4'd4,
		aluAndn  = 4'd5,
		aluOrn   = 4'd6,
		aluXnor  = 4'd7,
		aluPassA = 4'd8,
		aluPassB = 4'd9
	} aluFunc_t;

	// status flags, all active high
	typedef struct packed {
		logic overflow;
		logic carry;
		logic negative;
		logic zero;
	} aluFlags_t;

endpackage
